//--- Makefile
# Verilator flow for the microcoded core
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module tb_uc_core -f flist.f

obj_dir/sim: flist.f *.sv
	verilator --binary --timing -j 0 --top-module tb_uc_core -f flist.f -o sim

sim: obj_dir/sim
	-./obj_dir/sim > sim.log 2>&1
	cat sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
uc_pkg.sv
uc_rom.sv
uc_seq.sv
uc_biu.sv
uc_deu.sv
uc_core.sv
tb_uc_core.sv

//--- tb_uc_core.sv
`timescale 1ns/1ps

module tb_uc_core;
        import uc_pkg::*;

        logic   i_CLK = 1'b0;
        logic   arst_n = 1'b0;
        logic   wb_cyc, wb_stb, wb_we, halted;
        addr_t  wb_adr;
        data_t  wb_dat_o;
        data_t  wb_dat_i = '0;
        logic   wb_ack = 1'b0;

        data_t  mem [65536];                            // Slave memory
        data_t  ref_mem [65536];                        // Reference copy
        data_t  prog [$];                               // Program bytes from 0000
        addr_t  exp_adr [$];                            // Expected write stream
        data_t  exp_dat [$];
        logic [31:0] rng = 32'h02d5_09f2;
        string  test_name = "reset";
        int     writes_seen = 0;
        logic   busy = 1'b0;                            // Slave inside a cycle
        int     wait_left = 0;

        uc_core dut0 (
                .i_CLK(i_CLK), .arst_n(arst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
                .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o),
                .wb_dat_i(wb_dat_i), .wb_ack(wb_ack), .halted(halted)
        );

        initial begin
                forever #20 i_CLK = ~i_CLK;             // 40 ns period
        end

        function automatic logic [31:0] next_rand();
                rng = rng ^ (rng << 13);
                rng = rng ^ (rng >> 17);
                rng = rng ^ (rng << 5);
                return rng;
        endfunction

        function automatic int rand_below(input int n);
                logic [31:0] t;
                t = next_rand();
                return int'(t % n);
        endfunction

        function automatic data_t rand_byte();
                logic [31:0] t;
                t = next_rand();
                return t[7:0];
        endfunction

        function automatic data_t enc(input opcode_e op, input reg_idx_t r);
                return {op, r};                         // Opcode over register field
        endfunction

        task automatic stop_on_error(input string what);
                $display("%s", what);
                $display("Finished with errors");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_data(input data_t expected, input data_t actual);
                if (expected !== actual) begin
                        $display("[ERROR] %s: expected %02h, actual %02h",
                                 test_name, expected, actual);
                        stop_on_error("data mismatch");
                end
        endtask

        task automatic check_addr(input addr_t expected, input addr_t actual);
                if (expected !== actual) begin
                        $display("[ERROR] %s: expected %04h, actual %04h",
                                 test_name, expected, actual);
                        stop_on_error("address mismatch");
                end
        endtask

        // Interprets the program image and builds the write list
        function automatic void reference_run();
                data_t r [8];
                addr_t pc;
                data_t b;
                data_t imm;
                addr_t a;
                int    steps;
                logic  done;
                for (int i = 0; i < 8; i++) r[i] = '0;
                pc = RESET_PC;
                done = 1'b0;
                steps = 0;
                exp_adr.delete();
                exp_dat.delete();
                while (!done && steps < 4096) begin
                        b = ref_mem[pc];
                        pc = pc + 16'd1;
                        steps++;
                        imm = ref_mem[pc];              // Only used by two-byte ops
                        case (b[7:3])
                        OP_MOV_R_A : r[b[2:0]] = r[1];
                        OP_MOV_A_R : r[1] = r[b[2:0]];
                        OP_MVI     : begin
                                r[b[2:0]] = imm;
                                pc = pc + 16'd1;
                        end
                        OP_ADD     : r[1] = r[1] + r[b[2:0]];
                        OP_SUB     : r[1] = r[1] - r[b[2:0]];
                        OP_ANA     : r[1] = r[1] & r[b[2:0]];
                        OP_ORA     : r[1] = r[1] | r[b[2:0]];
                        OP_XRA     : r[1] = r[1] ^ r[b[2:0]];
                        OP_ADI     : begin
                                r[1] = r[1] + imm;
                                pc = pc + 16'd1;
                        end
                        OP_INR     : r[b[2:0]] = r[b[2:0]] + 8'd1;
                        OP_DCR     : r[b[2:0]] = r[b[2:0]] - 8'd1;
                        OP_LDAW    : begin
                                a = {r[0], imm};
                                r[1] = ref_mem[a];
                                pc = pc + 16'd1;
                        end
                        OP_STAW    : begin
                                a = {r[0], imm};
                                ref_mem[a] = r[1];
                                exp_adr.push_back(a);
                                exp_dat.push_back(r[1]);
                                pc = pc + 16'd1;
                        end
                        OP_HLT     : done = 1'b1;
                        default    : ;                  // Unknown runs as NOP
                        endcase
                end
        endfunction

        // Wishbone slave with 0 to 3 wait states
        always @(posedge i_CLK) begin : slave_model
                int w;
                if (!arst_n) begin
                        wb_ack <= 1'b0;
                        busy   <= 1'b0;
                end else if (wb_ack) begin
                        wb_ack <= 1'b0;
                        busy   <= 1'b0;
                        if (wb_we) mem[wb_adr] <= wb_dat_o;
                end else if (wb_cyc && wb_stb) begin
                        w = busy ? wait_left : rand_below(4);
                        busy <= 1'b1;
                        if (w == 0) begin
                                wb_ack   <= 1'b1;
                                wb_dat_i <= mem[wb_adr];
                        end else begin
                                wait_left <= w - 1;
                        end
                end
        end

        // Every acked write is checked against the reference in order
        always @(posedge i_CLK) begin
                if (arst_n && wb_cyc && wb_ack && wb_we) begin
                        if (exp_adr.size() == 0)
                                stop_on_error("DUT wrote more bytes than expected");
                        check_addr(exp_adr.pop_front(), wb_adr);
                        check_data(exp_dat.pop_front(), wb_dat_o);
                        writes_seen++;
                end
        end

        task automatic load_program();
                for (int a = 0; a < 65536; a++) begin
                        mem[a] = data_t'(a[15:8] ^ {a[6:0], a[7]} ^ 8'ha5);
                end
                foreach (prog[i]) mem[i] = prog[i];
                for (int a = 0; a < 65536; a++) ref_mem[a] = mem[a];
                reference_run();
        endtask

        task automatic run_program(input string name);
                int n;
                int expected_writes;
                test_name = name;
                load_program();
                expected_writes = exp_adr.size();
                @(posedge i_CLK);
                arst_n <= 1'b0;
                @(posedge i_CLK);
                @(negedge i_CLK);
                check_data(8'h00, {4'h0, wb_cyc, wb_stb, wb_we, halted});
                writes_seen = 0;
                @(posedge i_CLK);
                arst_n <= 1'b1;                         // Two cycles in reset
                n = 0;
                while (!wb_cyc && n < 50) begin
                        @(negedge i_CLK);
                        n++;
                end
                if (!wb_cyc) stop_on_error("no bus cycle started after reset");
                check_addr(RESET_PC, wb_adr);           // First fetch at 0000
                check_data(8'h00, {7'h0, wb_we});
                n = 0;
                while (!halted && n < 20000) begin
                        @(negedge i_CLK);
                        n++;
                end
                if (!halted) stop_on_error("timed out waiting for halted");
                n = 0;
                while (!wb_cyc && n < 60) begin          // Quiet window after HLT
                        @(negedge i_CLK);
                        n++;
                end
                if (wb_cyc) stop_on_error("bus cycle started after HLT");
                if (writes_seen != expected_writes)
                        stop_on_error("DUT wrote fewer bytes than expected");
        endtask

        task automatic push_random_program(input int count);
                int    k;
                data_t page;
                page = 8'h40 | (rand_byte() & 8'h3f);   // Keep clear of code
                prog.delete();
                prog.push_back(enc(OP_MVI, 3'd0));
                prog.push_back(page);
                for (int r = 1; r < 8; r++) begin
                        prog.push_back(enc(OP_MVI, reg_idx_t'(r)));
                        prog.push_back(rand_byte());
                end
                for (int i = 0; i < count; i++) begin
                        k = rand_below(9);
                        case (k)
                        0 : prog.push_back(enc(OP_ADD, reg_idx_t'(rand_below(8))));
                        1 : prog.push_back(enc(OP_SUB, reg_idx_t'(rand_below(8))));
                        2 : prog.push_back(enc(OP_ANA, reg_idx_t'(rand_below(8))));
                        3 : prog.push_back(enc(OP_ORA, reg_idx_t'(rand_below(8))));
                        4 : prog.push_back(enc(OP_XRA, reg_idx_t'(rand_below(8))));
                        5 : begin
                                prog.push_back(enc(OP_ADI, 3'd0));
                                prog.push_back(rand_byte());
                        end
                        6 : prog.push_back(enc(OP_MOV_A_R, reg_idx_t'(rand_below(8))));
                        7 : begin                       // Never touches V
                                prog.push_back(enc(OP_MVI, reg_idx_t'(1 + rand_below(7))));
                                prog.push_back(rand_byte());
                        end
                        default : prog.push_back(enc(OP_MOV_R_A, reg_idx_t'(2 + rand_below(6))));
                        endcase
                        prog.push_back(enc(OP_STAW, 3'd0));
                        prog.push_back(rand_byte());
                end
                prog.push_back(enc(OP_HLT, 3'd0));
        endtask

        initial begin
                prog = '{enc(OP_MVI, 3'd0), 8'h52, enc(OP_MVI, 3'd1), 8'hc3,
                         enc(OP_STAW, 3'd0), 8'h17, enc(OP_HLT, 3'd0)};
                run_program("mvi_staw");
                prog = '{enc(OP_MVI, 3'd0), 8'h61, enc(OP_LDAW, 3'd0), 8'h2e,
                         enc(OP_STAW, 3'd0), 8'h90, enc(OP_HLT, 3'd0)};
                run_program("ldaw_staw");
                prog = '{enc(OP_MVI, 3'd0), 8'h44, enc(OP_MVI, 3'd2), 8'hff,
                         enc(OP_INR, 3'd2), enc(OP_MOV_A_R, 3'd2),
                         enc(OP_STAW, 3'd0), 8'h01, enc(OP_MVI, 3'd3), 8'h00,
                         enc(OP_DCR, 3'd3), enc(OP_MOV_A_R, 3'd3),
                         enc(OP_STAW, 3'd0), 8'h02, enc(OP_HLT, 3'd0)};
                run_program("inr_dcr_wrap");
                for (int t = 0; t < 4; t++) begin
                        push_random_program(24);
                        run_program($sformatf("random_%0d", t));
                end
                $display("Finished with no errors");
                $finish;
        end

endmodule

//--- uc_biu.sv
`timescale 1ns/1ps

module uc_biu (
        input  logic               i_CLK,
        input  logic               arst_n,
        input  logic               bus_req,
        input  uc_pkg::bus_kind_e  uop_bus,
        input  uc_pkg::addr_t      ma,
        input  uc_pkg::data_t      md,
        output logic               bus_done,
        output uc_pkg::data_t      rdata,
        output logic               wb_cyc,
        output logic               wb_stb,
        output logic               wb_we,
        output uc_pkg::addr_t      wb_adr,
        output uc_pkg::data_t      wb_dat_o,
        input  uc_pkg::data_t      wb_dat_i,
        input  logic               wb_ack
);
        import uc_pkg::*;

        addr_t pc;                                      // Program counter
        logic  use_ma;                                  // Data cycle, not PC cycle

        assign use_ma = (uop_bus == BUS_RD) || (uop_bus == BUS_WR);

        // ROM word and MA/MD stay put for the whole cycle
        assign wb_adr   = use_ma ? ma : pc;
        assign wb_dat_o = md;
        assign wb_stb   = wb_cyc;                       // Classic single cycle

        assign bus_done = wb_cyc && wb_ack;

        // Read byte, taken by IR or MD on the ack cycle
        assign rdata = wb_dat_i;

        always_ff @(posedge i_CLK or negedge arst_n) begin
                if (!arst_n) begin
                        wb_cyc <= 1'b0;
                        wb_we  <= 1'b0;
                        pc     <= RESET_PC;
                end else begin
                        if (bus_req) begin
                                wb_cyc <= 1'b1;         // Open cycle
                                wb_we  <= (uop_bus == BUS_WR);
                        end else if (bus_done) begin
                                wb_cyc <= 1'b0;         // Drop after ack
                                wb_we  <= 1'b0;
                        end

                        // Step PC past opcode and operand bytes
                        if (bus_done && !use_ma) begin
                                pc <= pc + 1'b1;
                        end
                end
        end

endmodule

//--- uc_core.sv
`timescale 1ns/1ps

module uc_core (
        input  logic           i_CLK,
        input  logic           arst_n,
        output logic           wb_cyc,
        output logic           wb_stb,
        output logic           wb_we,
        output uc_pkg::addr_t  wb_adr,
        output uc_pkg::data_t  wb_dat_o,
        input  uc_pkg::data_t  wb_dat_i,
        input  logic           wb_ack,
        output logic           halted
);
        import uc_pkg::*;

        logic      rom_rd;                              // Sequencer to ROM
        uaddr_t    upc;
        opcode_e   op;
        uaddr_t    entry;                               // Dispatch result
        uop_src_e  uop_src;                             // Micro-step fields
        uop_dst_e  uop_dst;
        deu_op_e   uop_deu;
        bus_kind_e uop_bus;
        logic      xfer_en;
        logic      bus_req;
        logic      bus_done;                            // Ack from BIU
        data_t     rdata;
        reg_idx_t  r_idx;
        addr_t     ma;
        data_t     md;

        uc_seq u_seq (
                .i_CLK(i_CLK), .arst_n(arst_n), .uop_bus(uop_bus), .entry(entry),
                .bus_done(bus_done), .rdata(rdata), .rom_rd(rom_rd), .xfer_en(xfer_en),
                .bus_req(bus_req), .upc(upc), .op(op), .r_idx(r_idx), .halted(halted)
        );

        uc_rom u_rom (
                .i_CLK(i_CLK), .rom_rd(rom_rd), .upc(upc), .op(op), .entry(entry),
                .uop_src(uop_src), .uop_dst(uop_dst), .uop_deu(uop_deu), .uop_bus(uop_bus)
        );

        uc_biu u_biu (
                .i_CLK(i_CLK), .arst_n(arst_n), .bus_req(bus_req), .uop_bus(uop_bus),
                .ma(ma), .md(md), .bus_done(bus_done), .rdata(rdata),
                .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
                .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
        );

        uc_deu u_deu (
                .i_CLK(i_CLK), .arst_n(arst_n), .xfer_en(xfer_en), .uop_src(uop_src),
                .uop_dst(uop_dst), .uop_deu(uop_deu), .uop_bus(uop_bus), .r_idx(r_idx),
                .bus_done(bus_done), .rdata(rdata), .ma(ma), .md(md)
        );

endmodule

//--- uc_deu.sv
`timescale 1ns/1ps

module uc_deu (
        input  logic               i_CLK,
        input  logic               arst_n,
        input  logic               xfer_en,
        input  uc_pkg::uop_src_e   uop_src,
        input  uc_pkg::uop_dst_e   uop_dst,
        input  uc_pkg::deu_op_e    uop_deu,
        input  uc_pkg::bus_kind_e  uop_bus,
        input  uc_pkg::reg_idx_t   r_idx,
        input  logic               bus_done,
        input  uc_pkg::data_t      rdata,
        output uc_pkg::addr_t      ma,
        output uc_pkg::data_t      md
);
        import uc_pkg::*;

        data_t regs [8];                                // V A B C D E H L
        data_t src_val;
        data_t dst_val;
        data_t res;
        logic  md_load;

        // Operand and data reads land in MD
        assign md_load = bus_done && ((uop_bus == BUS_OPND) || (uop_bus == BUS_RD));

        always_comb begin
                case (uop_src)
                SRC_R   : src_val = regs[r_idx];
                SRC_A   : src_val = regs[REG_A];
                SRC_MD  : src_val = md;
                default : src_val = '0;
                endcase
        end

        always_comb begin
                case (uop_dst)
                DST_R   : dst_val = regs[r_idx];
                DST_A   : dst_val = regs[REG_A];
                DST_MA  : dst_val = ma[DATA_W-1:0];
                DST_MD  : dst_val = md;
                default : dst_val = '0;
                endcase
        end

        // 8-bit ALU, all results wrap
        always_comb begin
                case (uop_deu)
                DEU_ADD : res = dst_val + src_val;
                DEU_SUB : res = dst_val - src_val;
                DEU_AND : res = dst_val & src_val;
                DEU_OR  : res = dst_val | src_val;
                DEU_XOR : res = dst_val ^ src_val;
                DEU_INC : res = src_val + 1'b1;
                DEU_DEC : res = src_val - 1'b1;
                default : res = src_val;                // MOV
                endcase
        end

        always_ff @(posedge i_CLK or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 0; i < 8; i++) begin
                                regs[i] <= '0;
                        end
                        ma <= '0;
                        md <= '0;
                end else if (xfer_en) begin
                        case (uop_dst)
                        DST_R   : regs[r_idx] <= res;
                        DST_A   : regs[REG_A] <= res;
                        DST_MA  : ma <= {regs[REG_V], res};     // Working-area address
                        DST_MD  : md <= res;
                        default : ;
                        endcase
                end else if (md_load) begin
                        md <= rdata;
                end
        end

endmodule

//--- uc_pkg.sv
package uc_pkg;

        localparam int DATA_W  = 8;                     // Byte-wide datapath
        localparam int ADDR_W  = 16;                    // Bus address width
        localparam int UADDR_W = 6;                     // Micro-address width

        typedef logic [DATA_W-1:0]  data_t;
        typedef logic [ADDR_W-1:0]  addr_t;
        typedef logic [UADDR_W-1:0] uaddr_t;
        typedef logic [2:0]         reg_idx_t;          // V A B C D E H L

        localparam reg_idx_t REG_V = 3'd0;              // Working-area page
        localparam reg_idx_t REG_A = 3'd1;              // Accumulator

        // Upper five bits of the instruction byte
        typedef enum logic [4:0] {
                OP_NOP     = 5'h00,
                OP_MOV_R_A = 5'h01,                     // r <- A
                OP_MOV_A_R = 5'h02,                     // A <- r
                OP_MVI     = 5'h03,
                OP_ADD     = 5'h04,
                OP_SUB     = 5'h05,
                OP_ANA     = 5'h06,
                OP_ORA     = 5'h07,
                OP_XRA     = 5'h08,
                OP_ADI     = 5'h09,
                OP_INR     = 5'h0a,
                OP_DCR     = 5'h0b,
                OP_LDAW    = 5'h0c,                     // A <- (V, imm)
                OP_STAW    = 5'h0d,                     // (V, imm) <- A
                OP_HLT     = 5'h0e
        } opcode_e;

        typedef enum logic [1:0] {SRC_R, SRC_A, SRC_MD, SRC_NONE} uop_src_e;

        typedef enum logic [2:0] {DST_R, DST_A, DST_MA, DST_MD, DST_NONE} uop_dst_e;

        typedef enum logic [2:0] {
                DEU_MOV, DEU_ADD, DEU_SUB, DEU_AND,
                DEU_OR, DEU_XOR, DEU_INC, DEU_DEC
        } deu_op_e;

        typedef enum logic [2:0] {
                BUS_IDLE,                               // No bus cycle
                BUS_FETCH,                              // Opcode read at PC
                BUS_OPND,                               // Operand read at PC
                BUS_RD,                                 // Data read at MA
                BUS_WR                                  // Data write at MA
        } bus_kind_e;

        typedef enum logic [1:0] {S_LOAD, S_XFER, S_BUS, S_HALT} seq_state_e;

        // First micro-step of each sequence
        localparam uaddr_t ENT_RESET   = 6'd0;
        localparam uaddr_t ENT_NOP     = 6'd1;
        localparam uaddr_t ENT_MOV_R_A = 6'd2;
        localparam uaddr_t ENT_MOV_A_R = 6'd3;
        localparam uaddr_t ENT_MVI     = 6'd4;          // Two steps
        localparam uaddr_t ENT_ADD     = 6'd6;
        localparam uaddr_t ENT_SUB     = 6'd7;
        localparam uaddr_t ENT_ANA     = 6'd8;
        localparam uaddr_t ENT_ORA     = 6'd9;
        localparam uaddr_t ENT_XRA     = 6'd10;
        localparam uaddr_t ENT_ADI     = 6'd11;         // Two steps
        localparam uaddr_t ENT_INR     = 6'd13;
        localparam uaddr_t ENT_DCR     = 6'd14;
        localparam uaddr_t ENT_LDAW    = 6'd15;         // Three steps
        localparam uaddr_t ENT_STAW    = 6'd18;         // Four steps
        localparam uaddr_t ENT_HLT     = 6'd22;

        localparam addr_t RESET_PC = 16'h0000;

endpackage

//--- uc_rom.sv
`timescale 1ns/1ps

module uc_rom (
        input  logic               i_CLK,
        input  logic               rom_rd,
        input  uc_pkg::uaddr_t     upc,
        input  uc_pkg::opcode_e    op,
        output uc_pkg::uaddr_t     entry,
        output uc_pkg::uop_src_e   uop_src,
        output uc_pkg::uop_dst_e   uop_dst,
        output uc_pkg::deu_op_e    uop_deu,
        output uc_pkg::bus_kind_e  uop_bus
);
        import uc_pkg::*;

        typedef struct packed {
                uop_src_e  src;
                uop_dst_e  dst;
                deu_op_e   deu;
                bus_kind_e bus;
        } uop_t;

        uop_t mc;                                       // Current micro-step word

        assign uop_src = mc.src;
        assign uop_dst = mc.dst;
        assign uop_deu = mc.deu;
        assign uop_bus = mc.bus;

        always_ff @(posedge i_CLK) begin
                if (rom_rd) begin
                        case (upc)
                        ENT_RESET     : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_FETCH}; // First fetch
                        ENT_NOP       : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_FETCH};
                        ENT_MOV_R_A   : mc <= '{SRC_A,    DST_R,    DEU_MOV, BUS_FETCH}; // r<-A
                        ENT_MOV_A_R   : mc <= '{SRC_R,    DST_A,    DEU_MOV, BUS_FETCH}; // A<-r
                        ENT_MVI       : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_OPND};  // Get imm
                        ENT_MVI + 1   : mc <= '{SRC_MD,   DST_R,    DEU_MOV, BUS_FETCH}; // r<-MD
                        ENT_ADD       : mc <= '{SRC_R,    DST_A,    DEU_ADD, BUS_FETCH}; // A<-A+r
                        ENT_SUB       : mc <= '{SRC_R,    DST_A,    DEU_SUB, BUS_FETCH}; // A<-A-r
                        ENT_ANA       : mc <= '{SRC_R,    DST_A,    DEU_AND, BUS_FETCH};
                        ENT_ORA       : mc <= '{SRC_R,    DST_A,    DEU_OR,  BUS_FETCH};
                        ENT_XRA       : mc <= '{SRC_R,    DST_A,    DEU_XOR, BUS_FETCH};
                        ENT_ADI       : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_OPND};  // Get imm
                        ENT_ADI + 1   : mc <= '{SRC_MD,   DST_A,    DEU_ADD, BUS_FETCH}; // A<-A+MD
                        ENT_INR       : mc <= '{SRC_R,    DST_R,    DEU_INC, BUS_FETCH}; // r<-r+1
                        ENT_DCR       : mc <= '{SRC_R,    DST_R,    DEU_DEC, BUS_FETCH}; // r<-r-1
                        ENT_LDAW      : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_OPND};  // Get wa
                        ENT_LDAW + 1  : mc <= '{SRC_MD,   DST_MA,   DEU_MOV, BUS_RD};    // MA<-Vwa
                        ENT_LDAW + 2  : mc <= '{SRC_MD,   DST_A,    DEU_MOV, BUS_FETCH}; // A<-MD
                        ENT_STAW      : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_OPND};  // Get wa
                        ENT_STAW + 1  : mc <= '{SRC_MD,   DST_MA,   DEU_MOV, BUS_IDLE};  // MA<-Vwa
                        ENT_STAW + 2  : mc <= '{SRC_A,    DST_MD,   DEU_MOV, BUS_WR};    // MD<-A
                        ENT_STAW + 3  : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_FETCH};
                        ENT_HLT       : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_IDLE};  // Halt step
                        default       : mc <= '{SRC_NONE, DST_NONE, DEU_MOV, BUS_FETCH}; // nop
                        endcase
                end
        end

        // Opcode dispatch, unknown codes run as NOP
        always_comb begin
                case (op)
                OP_MOV_R_A : entry = ENT_MOV_R_A;
                OP_MOV_A_R : entry = ENT_MOV_A_R;
                OP_MVI     : entry = ENT_MVI;
                OP_ADD     : entry = ENT_ADD;
                OP_SUB     : entry = ENT_SUB;
                OP_ANA     : entry = ENT_ANA;
                OP_ORA     : entry = ENT_ORA;
                OP_XRA     : entry = ENT_XRA;
                OP_ADI     : entry = ENT_ADI;
                OP_INR     : entry = ENT_INR;
                OP_DCR     : entry = ENT_DCR;
                OP_LDAW    : entry = ENT_LDAW;
                OP_STAW    : entry = ENT_STAW;
                OP_HLT     : entry = ENT_HLT;
                default    : entry = ENT_NOP;
                endcase
        end

endmodule

//--- uc_seq.sv
`timescale 1ns/1ps

module uc_seq (
        input  logic               i_CLK,
        input  logic               arst_n,
        input  uc_pkg::bus_kind_e  uop_bus,
        input  uc_pkg::uaddr_t     entry,
        input  logic               bus_done,
        input  uc_pkg::data_t      rdata,
        output logic               rom_rd,
        output logic               xfer_en,
        output logic               bus_req,
        output uc_pkg::uaddr_t     upc,
        output uc_pkg::opcode_e    op,
        output uc_pkg::reg_idx_t   r_idx,
        output logic               halted
);
        import uc_pkg::*;

        seq_state_e state;
        uaddr_t     upc_q;                              // Address of current step
        logic       fetch_q;                            // New opcode waiting for dispatch
        data_t      ir;                                 // Instruction register

        // Dispatch address is used for the first step after a fetch
        assign upc = fetch_q ? entry : upc_q;

        assign op    = opcode_e'(ir[7:3]);              // Opcode field
        assign r_idx = ir[2:0];                         // Register field

        assign rom_rd  = (state == S_LOAD);             // ROM read strobe
        assign xfer_en = (state == S_XFER);             // Register transfer slot
        assign bus_req = (state == S_XFER) && (uop_bus != BUS_IDLE);
        assign halted  = (state == S_HALT);

        always_ff @(posedge i_CLK or negedge arst_n) begin
                if (!arst_n) begin
                        state   <= S_LOAD;
                        upc_q   <= ENT_RESET;
                        fetch_q <= 1'b0;
                        ir      <= '0;
                end else begin
                        case (state)
                        S_LOAD: begin
                                upc_q   <= upc;         // Remember dispatched address
                                fetch_q <= 1'b0;
                                state   <= S_XFER;
                        end
                        S_XFER: begin
                                if (uop_bus != BUS_IDLE) begin
                                        state <= S_BUS; // BIU starts the cycle
                                end else if (upc_q == ENT_HLT) begin
                                        state <= S_HALT;
                                end else begin
                                        upc_q <= upc_q + 1'b1;
                                        state <= S_LOAD;
                                end
                        end
                        S_BUS: begin
                                if (bus_done) begin
                                        if (uop_bus == BUS_FETCH) begin
                                                ir      <= rdata;       // Latch opcode
                                                fetch_q <= 1'b1;
                                        end else begin
                                                upc_q <= upc_q + 1'b1;
                                        end
                                        state <= S_LOAD;
                                end
                        end
                        default: begin
                                state <= S_HALT;        // Stuck until reset
                        end
                        endcase
                end
        end

endmodule
